// ==== all.f ====
+incdir+include
logic/mem_arb_pkg.sv
logic/match_queue_if.sv
logic/arbiter_matching_queue.sv
logic/memory_pipe_arbiter.sv
logic/memory_pipe_top.sv
tb/mem_responder.sv
tb/tb_memory_pipe.sv

// ==== Makefile ====
# Verilator build for the memory pipe arbiter testbench
VERILATOR ?= verilator
TOP ?= tb_memory_pipe
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard logic/*.sv tb/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^TESTS PASSED$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tb_memory_pipe.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "mem_arb_params.svh"

module tb_memory_pipe
	import mem_arb_pkg::*;
();

	localparam int AW = `MEM_ARB_ADDR_W;
	localparam int WW = `MEM_ARB_WDATA_W;
	localparam int RW = `MEM_ARB_RDATA_W;
	localparam int FW = `MEM_ARB_FLAGS_W;
	localparam int PW = `MEM_ARB_PDT_W;
	localparam int REQ_W = 1 + 2 + PW + 2 + 4 + 1 + AW + WW;
	localparam int NUM_TXN = 120;
	localparam int MAX_LAT = 30;

	logic iCLOCK;
	logic inRESET;
	logic data_req;
	logic [1:0] data_order;
	logic [3:0] data_mask;
	logic data_rw;
	logic [1:0] data_mmumod;
	logic [PW-1:0] data_pdt;
	logic [AW-1:0] data_addr;
	logic [WW-1:0] data_wdata;
	logic data_busy;
	logic inst_req;
	logic [1:0] inst_mmumod;
	logic [PW-1:0] inst_pdt;
	logic [AW-1:0] inst_addr;
	logic inst_busy;
	logic flush_cmd;
	wire data_lock;
	wire data_valid;
	wire data_pagefault;
	wire [RW-1:0] data_rdata;
	wire [FW-1:0] data_mmu_flags;
	wire inst_lock;
	wire inst_valid;
	wire inst_pagefault;
	wire inst_queue_flush;
	wire [RW-1:0] inst_rdata;
	wire [FW-1:0] inst_mmu_flags;
	wire mem_req;
	wire mem_lock;
	wire mem_data_store_ack;
	wire [1:0] mem_mmu_mode;
	wire [PW-1:0] mem_pdt;
	wire [1:0] mem_order;
	wire [3:0] mem_mask;
	wire mem_rw;
	wire [AW-1:0] mem_addr;
	wire [WW-1:0] mem_wdata;
	wire mem_valid;
	wire mem_busy;
	wire mem_store_ack;
	wire mem_pagefault;
	wire mem_queue_flush;
	wire [RW-1:0] mem_rdata;
	wire [FW-1:0] mem_mmu_flags;

	integer seed;
	// Scoreboard entries are {source, store, address}
	logic [AW+1:0] exp_q [$];
	logic [REQ_W-1:0] req_exp [$];
	logic [AW-1:0] pend_inst [$];
	logic [AW:0] pend_data [$];
	logic prev_flush;
	time data_acc_time;
	time inst_acc_time;

	memory_pipe_top dut (.*);

	mem_responder memory (.*);

	always #20 iCLOCK = ~iCLOCK;

	task automatic report_mismatch(input string what);
		$display("** Error at %0t ns: %s", $time, what);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	// Expected {pagefault, flags, word} for an address
	function automatic logic [RW+FW:0] expected_response(input logic [AW-1:0] addr);
		logic [RW-1:0] word;
		logic [FW-1:0] flags;
		word = {~addr, addr ^ 32'h5a5a0f0f};
		flags = addr[27:0] ^ 28'h0c3a5a5;
		return {^addr, flags, word};
	endfunction

	function automatic logic [AW-1:0] random_addr();
		logic [31:0] r;
		r = $random(seed);
		return {r[AW-1:2], 2'b00};
	endfunction

	task automatic check_mem_request(input logic [REQ_W-1:0] want);
		logic [REQ_W-1:0] got;
		got = {mem_data_store_ack, mem_mmu_mode, mem_pdt, mem_order, mem_mask,
			mem_rw, mem_addr, mem_wdata};
		if (got !== want)
			report_mismatch($sformatf("memory request %h, expected %h", got, want));
	endtask

	task automatic check_inst_response(input logic [AW-1:0] addr);
		logic [RW+FW:0] got;
		got = {inst_pagefault, inst_mmu_flags, inst_rdata};
		if (got !== expected_response(addr))
			report_mismatch($sformatf("fetch %h returned %h", addr, got));
	endtask

	task automatic check_data_response(input logic store, input logic [AW-1:0] addr);
		logic [RW+FW:0] got;
		got = {data_pagefault, data_mmu_flags, data_rdata};
		// A store acknowledge carries no data worth checking
		if (!store && got !== expected_response(addr))
			report_mismatch($sformatf("load %h returned %h", addr, got));
	endtask

	// Everything is sampled at the falling edge, before the next rising one
	always @(negedge iCLOCK) begin : monitor
		logic [AW+1:0] ent;
		if (inRESET) begin
			if (inst_queue_flush !== prev_flush)
				report_mismatch("inst_queue_flush does not follow mem_queue_flush");
			prev_flush = mem_queue_flush;
			if (mem_busy !== (data_busy || inst_busy))
				report_mismatch("mem_busy does not follow the two busy inputs");
			if (inst_busy && inst_valid)
				report_mismatch("inst_valid raised while inst_busy is high");
			if (mem_lock && !(inst_lock && data_lock))
				report_mismatch("core request not locked while mem_lock is high");
			if (data_req && !inst_lock)
				report_mismatch("fetch not locked behind a data request");
			if (inst_valid) begin
				if (pend_inst.size() == 0)
					report_failure("Instruction response arrived with none expected");
				check_inst_response(pend_inst.pop_front());
			end
			if (data_valid) begin
				if (pend_data.size() == 0)
					report_failure("Data response arrived with none expected");
				ent = {1'b0, pend_data.pop_front()};
				check_data_response(ent[AW], ent[AW-1:0]);
			end
			if (mem_req && !mem_lock) begin
				if (req_exp.size() == 0)
					report_failure("Memory request issued with no core request behind it");
				check_mem_request(req_exp.pop_front());
			end
			if (mem_valid && !mem_busy) begin
				if (exp_q.size() == 0)
					report_failure("Memory response with nothing outstanding");
				ent = exp_q.pop_front();
				if (mem_store_ack !== ent[AW])
					report_mismatch("store acknowledge out of order");
				if (ent[AW+1] == SRC_INST)
					pend_inst.push_back(ent[AW-1:0]);
				else
					pend_data.push_back(ent[AW:0]);
			end
			if (data_req && !data_lock) begin
				data_acc_time = $time;
				exp_q.push_back({SRC_DATA, data_rw, data_addr});
				req_exp.push_back({data_rw, data_mmumod, data_pdt, data_order, data_mask,
					data_rw, data_addr, data_wdata});
			end
			if (inst_req && !inst_lock) begin
				inst_acc_time = $time;
				exp_q.push_back({SRC_INST, 1'b0, inst_addr});
				req_exp.push_back({1'b0, inst_mmumod, inst_pdt, FETCH_ORDER, FETCH_MASK,
					1'b0, inst_addr, {WW{1'b0}}});
			end
			if (mem_queue_flush) begin
				exp_q.delete();
				req_exp.delete();
			end
		end
	end

	task automatic issue_data(input logic rw, input logic [AW-1:0] addr,
		input logic [WW-1:0] wdata);
		@(posedge iCLOCK);
		#2;
		data_req = 1'b1;
		data_rw = rw;
		data_addr = addr;
		data_wdata = wdata;
		data_order = rw ? 2'd1 : 2'd2;
		data_mask = rw ? 4'h3 : 4'hf;
		data_mmumod = 2'd1;
		data_pdt = 32'h00040000 ^ addr;
		@(negedge iCLOCK);
		while (data_lock)
			@(negedge iCLOCK);
		@(posedge iCLOCK);
		#2;
		data_req = 1'b0;
	endtask

	task automatic issue_fetch(input logic [AW-1:0] addr);
		@(posedge iCLOCK);
		#2;
		inst_req = 1'b1;
		inst_addr = addr;
		inst_mmumod = 2'd2;
		inst_pdt = 32'h00080000 ^ addr;
		@(negedge iCLOCK);
		while (inst_lock)
			@(negedge iCLOCK);
		@(posedge iCLOCK);
		#2;
		inst_req = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_q.size() || req_exp.size() || pend_inst.size() || pend_data.size())
			@(negedge iCLOCK);
	endtask

	initial begin
		#(NUM_TXN * MAX_LAT * 40);
		report_failure("Watchdog expired before all transactions completed");
	end

	initial begin
		seed = 32'h82af18ab;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		data_req = 1'b0;
		data_order = 2'd0;
		data_mask = 4'h0;
		data_rw = 1'b0;
		data_mmumod = 2'd0;
		data_pdt = '0;
		data_addr = '0;
		data_wdata = '0;
		data_busy = 1'b0;
		inst_req = 1'b0;
		inst_mmumod = 2'd0;
		inst_pdt = '0;
		inst_addr = '0;
		inst_busy = 1'b0;
		flush_cmd = 1'b0;
		prev_flush = 1'b0;
		repeat (10) @(posedge iCLOCK);
		#2;
		inRESET = 1'b1;

		// Single load, then single fetch
		issue_data(1'b0, 32'h00001000, '0);
		wait_idle();
		issue_fetch(32'h00000100);
		wait_idle();

		// Both sides at once, data wins
		fork
			issue_data(1'b0, 32'h00002000, '0);
			issue_fetch(32'h00003000);
		join
		if (data_acc_time >= inst_acc_time)
			report_mismatch("fetch accepted before the data request");
		wait_idle();

		// Random mix under random mem_lock
		fork
			begin
				repeat (40) begin
					repeat ($random(seed) & 3) @(posedge iCLOCK);
					issue_data(1'b0, random_addr(), '0);
				end
			end
			repeat (60) issue_fetch(random_addr());
			begin
				// Data side stalls now and then
				repeat (150) begin
					@(posedge iCLOCK);
					#2;
					data_busy = (($random(seed) & 7) == 0);
				end
				data_busy = 1'b0;
			end
		join
		wait_idle();

		// Store among pending fetches
		fork
			repeat (3) issue_fetch(random_addr());
			begin
				@(posedge iCLOCK);
				issue_data(1'b1, 32'h00004000, 32'hcafe1234);
			end
		join
		wait_idle();

		// Fetch response caught in its register by inst_busy
		fork
			repeat (3) issue_fetch(random_addr());
			begin
				@(negedge iCLOCK);
				while (!mem_valid || mem_busy)
					@(negedge iCLOCK);
				@(posedge iCLOCK);
				#2;
				inst_busy = 1'b1;
			end
		join
		repeat (8) @(posedge iCLOCK);
		#2;
		inst_busy = 1'b0;
		wait_idle();

		// Flush with fetches stuck behind busy
		@(posedge iCLOCK);
		#2;
		inst_busy = 1'b1;
		repeat (3) issue_fetch(random_addr());
		repeat (6) @(posedge iCLOCK);
		#2;
		flush_cmd = 1'b1;
		@(posedge iCLOCK);
		#2;
		flush_cmd = 1'b0;
		repeat (3) @(posedge iCLOCK);
		#2;
		inst_busy = 1'b0;
		wait_idle();

		// Pipe still works after the flush
		issue_fetch(32'h00000200);
		issue_data(1'b0, 32'h00005000, '0);
		wait_idle();
		repeat (4) @(posedge iCLOCK);

		if (exp_q.size() || pend_inst.size() || pend_data.size()) begin
			report_failure("Responses still outstanding at the end of the run");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== tb/mem_responder.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "mem_arb_params.svh"

module mem_responder (
	input wire iCLOCK,
	input wire inRESET,
	input wire mem_req,
	input wire mem_data_store_ack,
	input wire [`MEM_ARB_ADDR_W-1:0] mem_addr,
	input wire mem_busy,
	input wire flush_cmd,
	output logic mem_lock,
	output logic mem_valid,
	output logic mem_store_ack,
	output logic mem_pagefault,
	output logic mem_queue_flush,
	output logic [`MEM_ARB_RDATA_W-1:0] mem_rdata,
	output logic [`MEM_ARB_FLAGS_W-1:0] mem_mmu_flags
);

	integer seed;
	logic [`MEM_ARB_ADDR_W-1:0] pend_addr [$];
	logic pend_store [$];
	logic accept;
	logic taken;
	logic flush_seen;
	logic accept_store;
	logic [`MEM_ARB_ADDR_W-1:0] accept_addr;
	logic [`MEM_ARB_ADDR_W-1:0] head;
	int wait_cnt;

	initial begin
		seed = 32'h82af18ab;
		mem_lock = 1'b0;
		mem_valid = 1'b0;
		mem_store_ack = 1'b0;
		mem_pagefault = 1'b0;
		mem_queue_flush = 1'b0;
		mem_rdata = '0;
		mem_mmu_flags = '0;
		wait_cnt = 0;
		forever begin
			// Handshakes are settled by the falling edge
			@(negedge iCLOCK);
			accept = mem_req && !mem_lock;
			accept_addr = mem_addr;
			accept_store = mem_data_store_ack;
			taken = mem_valid && !mem_busy;
			flush_seen = flush_cmd;
			@(posedge iCLOCK);
			#2;
			if (!inRESET) begin
				pend_addr.delete();
				pend_store.delete();
				mem_valid = 1'b0;
				mem_lock = 1'b0;
				mem_queue_flush = 1'b0;
			end else if (flush_seen) begin
				// Drop everything outstanding, no accept during the flush
				pend_addr.delete();
				pend_store.delete();
				mem_valid = 1'b0;
				mem_lock = 1'b1;
				mem_queue_flush = 1'b1;
			end else begin
				mem_queue_flush = 1'b0;
				if (accept) begin
					pend_addr.push_back(accept_addr);
					pend_store.push_back(accept_store);
				end
				if (taken) begin
					mem_valid = 1'b0;
					void'(pend_addr.pop_front());
					void'(pend_store.pop_front());
					wait_cnt = $random(seed) & 3;
				end
				mem_lock = (($random(seed) & 3) == 0);
				// Held response stays put while busy
				if (!mem_valid && pend_addr.size() > 0) begin
					if (wait_cnt > 0) begin
						wait_cnt = wait_cnt - 1;
					end else begin
						head = pend_addr[0];
						mem_valid = 1'b1;
						mem_store_ack = pend_store[0];
						mem_rdata = {~head, head ^ 32'h5a5a0f0f};
						mem_mmu_flags = head[27:0] ^ 28'h0c3a5a5;
						mem_pagefault = ^head;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/memory_pipe_top.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "mem_arb_params.svh"

module memory_pipe_top (
	input wire iCLOCK,
	input wire inRESET,
	// Data request
	input wire data_req,
	output wire data_lock,
	input wire [1:0] data_order,
	input wire [3:0] data_mask,
	input wire data_rw,
	input wire [1:0] data_mmumod,
	input wire [`MEM_ARB_PDT_W-1:0] data_pdt,
	input wire [`MEM_ARB_ADDR_W-1:0] data_addr,
	input wire [`MEM_ARB_WDATA_W-1:0] data_wdata,
	// Data response
	output wire data_valid,
	input wire data_busy,
	output wire data_pagefault,
	output wire [`MEM_ARB_RDATA_W-1:0] data_rdata,
	output wire [`MEM_ARB_FLAGS_W-1:0] data_mmu_flags,
	// Instruction request
	input wire inst_req,
	output wire inst_lock,
	input wire [1:0] inst_mmumod,
	input wire [`MEM_ARB_PDT_W-1:0] inst_pdt,
	input wire [`MEM_ARB_ADDR_W-1:0] inst_addr,
	// Instruction response
	output wire inst_valid,
	input wire inst_busy,
	output wire inst_pagefault,
	output wire inst_queue_flush,
	output wire [`MEM_ARB_RDATA_W-1:0] inst_rdata,
	output wire [`MEM_ARB_FLAGS_W-1:0] inst_mmu_flags,
	// Memory request
	output wire mem_req,
	input wire mem_lock,
	output wire mem_data_store_ack,
	output wire [1:0] mem_mmu_mode,
	output wire [`MEM_ARB_PDT_W-1:0] mem_pdt,
	output wire [1:0] mem_order,
	output wire [3:0] mem_mask,
	output wire mem_rw,
	output wire [`MEM_ARB_ADDR_W-1:0] mem_addr,
	output wire [`MEM_ARB_WDATA_W-1:0] mem_wdata,
	// Memory response
	input wire mem_valid,
	output wire mem_busy,
	input wire mem_store_ack,
	input wire mem_pagefault,
	input wire mem_queue_flush,
	input wire [`MEM_ARB_RDATA_W-1:0] mem_rdata,
	input wire [`MEM_ARB_FLAGS_W-1:0] mem_mmu_flags
);

	match_queue_if mq_if ();

	memory_pipe_arbiter u_arbiter (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.data_req(data_req),
		.data_lock(data_lock),
		.data_order(data_order),
		.data_mask(data_mask),
		.data_rw(data_rw),
		.data_mmumod(data_mmumod),
		.data_pdt(data_pdt),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_valid(data_valid),
		.data_busy(data_busy),
		.data_pagefault(data_pagefault),
		.data_rdata(data_rdata),
		.data_mmu_flags(data_mmu_flags),
		.inst_req(inst_req),
		.inst_lock(inst_lock),
		.inst_mmumod(inst_mmumod),
		.inst_pdt(inst_pdt),
		.inst_addr(inst_addr),
		.inst_valid(inst_valid),
		.inst_busy(inst_busy),
		.inst_pagefault(inst_pagefault),
		.inst_queue_flush(inst_queue_flush),
		.inst_rdata(inst_rdata),
		.inst_mmu_flags(inst_mmu_flags),
		.mem_req(mem_req),
		.mem_lock(mem_lock),
		.mem_data_store_ack(mem_data_store_ack),
		.mem_mmu_mode(mem_mmu_mode),
		.mem_pdt(mem_pdt),
		.mem_order(mem_order),
		.mem_mask(mem_mask),
		.mem_rw(mem_rw),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_valid(mem_valid),
		.mem_busy(mem_busy),
		.mem_store_ack(mem_store_ack),
		.mem_pagefault(mem_pagefault),
		.mem_queue_flush(mem_queue_flush),
		.mem_rdata(mem_rdata),
		.mem_mmu_flags(mem_mmu_flags),
		.mq(mq_if.arb)
	);

	// Tags of outstanding loads and fetches, in issue order
	arbiter_matching_queue #(
		.DEPTH(`MEM_ARB_QUEUE_DEPTH),
		.DEPTH_N(`MEM_ARB_QUEUE_DEPTH_N)
	) u_queue (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.q(mq_if.queue)
	);

endmodule

`default_nettype wire

// ==== logic/memory_pipe_arbiter.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "mem_arb_params.svh"

module memory_pipe_arbiter
	import mem_arb_pkg::*;
(
	input wire iCLOCK,
	input wire inRESET,
	// Data request
	input wire data_req,
	output logic data_lock,
	input wire [1:0] data_order,
	input wire [3:0] data_mask,
	input wire data_rw,
	input wire [1:0] data_mmumod,
	input wire [`MEM_ARB_PDT_W-1:0] data_pdt,
	input wire [`MEM_ARB_ADDR_W-1:0] data_addr,
	input wire [`MEM_ARB_WDATA_W-1:0] data_wdata,
	// Data response
	output logic data_valid,
	input wire data_busy,
	output logic data_pagefault,
	output logic [`MEM_ARB_RDATA_W-1:0] data_rdata,
	output logic [`MEM_ARB_FLAGS_W-1:0] data_mmu_flags,
	// Instruction request
	input wire inst_req,
	output logic inst_lock,
	input wire [1:0] inst_mmumod,
	input wire [`MEM_ARB_PDT_W-1:0] inst_pdt,
	input wire [`MEM_ARB_ADDR_W-1:0] inst_addr,
	// Instruction response
	output logic inst_valid,
	input wire inst_busy,
	output logic inst_pagefault,
	output logic inst_queue_flush,
	output logic [`MEM_ARB_RDATA_W-1:0] inst_rdata,
	output logic [`MEM_ARB_FLAGS_W-1:0] inst_mmu_flags,
	// Memory request
	output logic mem_req,
	input wire mem_lock,
	output logic mem_data_store_ack,
	output logic [1:0] mem_mmu_mode,
	output logic [`MEM_ARB_PDT_W-1:0] mem_pdt,
	output logic [1:0] mem_order,
	output logic [3:0] mem_mask,
	output logic mem_rw,
	output logic [`MEM_ARB_ADDR_W-1:0] mem_addr,
	output logic [`MEM_ARB_WDATA_W-1:0] mem_wdata,
	// Memory response
	input wire mem_valid,
	output logic mem_busy,
	input wire mem_store_ack,
	input wire mem_pagefault,
	input wire mem_queue_flush,
	input wire [`MEM_ARB_RDATA_W-1:0] mem_rdata,
	input wire [`MEM_ARB_FLAGS_W-1:0] mem_mmu_flags,
	// Matching queue
	match_queue_if.arb mq
);

	logic common_lock;
	logic data_accept;
	logic inst_accept;
	logic take_resp;
	logic inst_take;
	logic data_take;
	logic inst_valid_r;

	// Data side wins, fetch waits behind any data request
	assign common_lock = mem_lock || mq.full;
	assign inst_lock = common_lock || data_req;
	assign data_lock = common_lock || (inst_req && !data_req);
	assign data_accept = data_req && !data_lock;
	assign inst_accept = inst_req && !inst_lock;

	// Stores only get an acknowledge, so they carry no tag
	assign mq.wr_req = data_accept ? !data_rw : inst_accept;
	assign mq.wr_tag = data_accept ? SRC_DATA : SRC_INST;
	assign mq.flush = mem_queue_flush;

	// Memory request control
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			mem_req <= 1'b0;
			mem_data_store_ack <= 1'b0;
		end else if (mem_queue_flush) begin
			mem_req <= 1'b0;
			mem_data_store_ack <= 1'b0;
		end else if (!mem_lock) begin
			// Current request is taken by memory on this edge
			mem_req <= data_accept || inst_accept;
			mem_data_store_ack <= data_accept && data_rw;
		end
	end

	// Request fields hold until a new request is accepted
	always_ff @(posedge iCLOCK) begin
		if (data_accept) begin
			mem_mmu_mode <= data_mmumod;
			mem_pdt <= data_pdt;
			mem_order <= data_order;
			mem_mask <= data_mask;
			mem_rw <= data_rw;
			mem_addr <= data_addr;
			mem_wdata <= data_wdata;
		end else if (inst_accept) begin
			mem_mmu_mode <= inst_mmumod;
			mem_pdt <= inst_pdt;
			mem_order <= FETCH_ORDER;
			mem_mask <= FETCH_MASK;
			mem_rw <= 1'b0;
			mem_addr <= inst_addr;
			mem_wdata <= '0;
		end
	end

	// Memory holds its response while either side is busy
	assign mem_busy = data_busy || inst_busy;
	assign take_resp = mem_valid && !mem_busy;
	assign mq.rd_req = take_resp && !mem_store_ack;

	assign inst_take = take_resp && !mem_store_ack && mq.rd_valid && (mq.rd_tag == SRC_INST);
	assign data_take = take_resp
		&& (mem_store_ack || (mq.rd_valid && (mq.rd_tag == SRC_DATA)));

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			inst_valid_r <= 1'b0;
			data_valid <= 1'b0;
			inst_queue_flush <= 1'b0;
		end else begin
			if (!inst_busy) begin
				inst_valid_r <= inst_take;
			end
			data_valid <= data_take;
			inst_queue_flush <= mem_queue_flush;
		end
	end

	// Response words, loaded only when a response is routed there
	always_ff @(posedge iCLOCK) begin
		if (inst_take) begin
			inst_pagefault <= mem_pagefault;
			inst_rdata <= mem_rdata;
			inst_mmu_flags <= mem_mmu_flags;
		end
		if (data_take) begin
			data_pagefault <= mem_pagefault;
			data_rdata <= mem_rdata;
			data_mmu_flags <= mem_mmu_flags;
		end
	end

	assign inst_valid = inst_valid_r && !inst_busy;

	// Memory sees a steady request while it stalls us
	a_mem_req_stable: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(mem_req && mem_lock && !mem_queue_flush) |=> (mem_req
		&& $stable({mem_data_store_ack, mem_mmu_mode, mem_pdt, mem_order,
		mem_mask, mem_rw, mem_addr, mem_wdata})));

	// No valid during busy, and the pending fetch response survives it
	a_inst_busy_hold: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(inst_busy && inst_valid_r) |-> (!inst_valid ##1 inst_valid_r));

endmodule

`default_nettype wire

// ==== logic/arbiter_matching_queue.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "mem_arb_params.svh"

module arbiter_matching_queue
	import mem_arb_pkg::*;
#(
	parameter int DEPTH = `MEM_ARB_QUEUE_DEPTH,
	parameter int DEPTH_N = `MEM_ARB_QUEUE_DEPTH_N
) (
	input wire iCLOCK,
	input wire inRESET,
	match_queue_if.queue q
);

	localparam logic [DEPTH_N:0] FULL_COUNT = (DEPTH_N + 1)'(DEPTH);

	logic tag_mem [DEPTH];
	logic [DEPTH_N-1:0] wr_ptr;
	logic [DEPTH_N-1:0] rd_ptr;
	logic [DEPTH_N:0] count;
	logic push;
	logic pop;

	assign push = q.wr_req && !q.full;
	assign pop = q.rd_req && q.rd_valid;

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (q.flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (push) begin
			tag_mem[wr_ptr] <= q.wr_tag;
		end
	end

	assign q.full = (count == FULL_COUNT);
	assign q.rd_valid = (count != '0);
	// Empty queue reads as a fetch tag, rd_valid qualifies it
	assign q.rd_tag = q.rd_valid ? tag_mem[rd_ptr] : SRC_INST;

	// Arbiter folds full into its lock, so a write here means a lost tag
	a_no_write_full: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(q.wr_req && q.full && !q.flush));

	// A non-store response with no tag left means memory answered too often
	a_no_pop_empty: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(q.rd_req && !q.rd_valid && !q.flush));

endmodule

`default_nettype wire

// ==== logic/match_queue_if.sv ====
`default_nettype none
`timescale 1ns/100ps

interface match_queue_if;

	// Write side
	logic wr_req;
	logic wr_tag;
	logic full;

	// Read side, head shown combinationally
	logic rd_req;
	logic rd_valid;
	logic rd_tag;

	// Empties the queue, wins over write and pop
	logic flush;

	modport arb (
		output wr_req,
		output wr_tag,
		output rd_req,
		output flush,
		input full,
		input rd_valid,
		input rd_tag
	);

	modport queue (
		input wr_req,
		input wr_tag,
		input rd_req,
		input flush,
		output full,
		output rd_valid,
		output rd_tag
	);

endinterface

`default_nettype wire

// ==== logic/mem_arb_pkg.sv ====
`default_nettype none

package mem_arb_pkg;

	// Source tags kept in the matching queue
	localparam logic SRC_INST = 1'b0;
	localparam logic SRC_DATA = 1'b1;

	// Every instruction fetch is a full word read
	localparam logic [1:0] FETCH_ORDER = 2'd2;
	localparam logic [3:0] FETCH_MASK = 4'hf;

endpackage

`default_nettype wire

// ==== include/mem_arb_params.svh ====
`ifndef MEM_ARB_PARAMS_SVH
`define MEM_ARB_PARAMS_SVH

// Outstanding tagged requests in the matching queue
`define MEM_ARB_QUEUE_DEPTH 16
// Pointer width, log2 of the depth
`define MEM_ARB_QUEUE_DEPTH_N 4

// Request side widths
`define MEM_ARB_ADDR_W 32
`define MEM_ARB_WDATA_W 32
`define MEM_ARB_PDT_W 32

// Response side widths
`define MEM_ARB_RDATA_W 64
`define MEM_ARB_FLAGS_W 28

`endif
